/* design/memPkg.sv */
// Memory subsystem shared definitions
package memPkg;

   ////////////////////////////////////////
   // Word types, big-endian bit numbering
   ////////////////////////////////////////

   // Backplane data or flagged address word
   typedef logic [0:35] busWord;

   // IO register address, low half of the word
   typedef logic [18:35] ioAddr;

   // Physical memory address, 1M words
   typedef logic [16:35] memAddr;

   // Backplane device number
   typedef logic [0:3] devNum;

   // One-hot clock phase, phase 1 in bit 1
   typedef logic [1:4] phaseVec;

   ////////////////////////////////////////
   // Address word fields
   ////////////////////////////////////////

   // Cycle flags in the left half
   localparam int flagRead   = 3;
   localparam int flagWrTest = 4;
   localparam int flagWrite  = 5;
   localparam int flagIo     = 6;
   localparam int flagPhys   = 8;
   localparam int flagAcRef  = 13;

   // Device number field
   localparam int devFirst = 14;
   localparam int devLast  = 17;

   // Address fields, both end at the last bit
   localparam int memAddrFirst = 16;
   localparam int ioAddrFirst  = 18;
   localparam int wordLast     = 35;

   ////////////////////////////////////////
   // Status register bit positions
   ////////////////////////////////////////

   localparam int statBitPe = 3;   // Parity error, read and write
   localparam int statBitEe = 4;   // ECC enable, read only
   localparam int statBitPf = 12;  // Power failure, clear only
   localparam int statBitEd = 35;  // ECC disable, write only

endpackage

/* design/memReqIf.sv */
// Decoded bus cycle interface
`timescale 1ns/1ps

interface memReqIf;

   // Memory read, not IO
   logic memRead;

   // Memory write, not IO and not an AC reference
   logic memWrite;

   // Write of our own status register
   logic msrWrite;

   // Physical SRAM word address
   memPkg::memAddr addr;

   // Write data straight from the bus
   memPkg::busWord wrData;

   // Decoder side
   modport src (
      output memRead,
      output memWrite,
      output msrWrite,
      output addr,
      output wrData
   );

   // Status register and SRAM controller side
   modport sink (
      input memRead,
      input memWrite,
      input msrWrite,
      input addr,
      input wrData
   );

endinterface

/* design/clkPhaseSeq.sv */
// Four-phase clock sequencer
`timescale 1ns/1ps

module clkPhaseSeq (
   input  logic            clkR,
   input  logic            rst,
   output memPkg::phaseVec phase
);

   ////////////////////////////////////////
   // Phase rotation
   ////////////////////////////////////////

   memPkg::phaseVec phaseQ;

   // Start in phase 1 and step once per clock
   always_ff @(posedge clkR or posedge rst)
   begin
      if (rst)
      begin
         phaseQ <= 4'b1000;
      end
      else
      begin
         // Phase 4 wraps around to phase 1
         phaseQ <= {phaseQ[4], phaseQ[1:3]};
      end
   end

   assign phase = phaseQ;

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // SRAM strobes downstream depend on exactly one phase being active
   phaseOneHot : assert property (
      @(posedge clkR) disable iff (rst) $onehot(phaseQ)
   );

endmodule

/* design/memBusDecode.sv */
// Backplane bus cycle decoder
`timescale 1ns/1ps

module memBusDecode #(
   parameter memPkg::devNum memDev  = 4'd0,
   parameter memPkg::ioAddr msrAddr = 18'o100000
) (
   input  logic           busReq,
   input  memPkg::busWord busAddr,
   input  memPkg::busWord busDataIn,
   input  memPkg::busWord ssramRdData,
   input  memPkg::busWord statWord,
   output logic           busAck,
   output memPkg::busWord busDataOut,
   memReqIf.src           req
);

   ////////////////////////////////////////
   // Address word fields
   ////////////////////////////////////////

   logic          busRead;
   logic          busWrTest;
   logic          busWrite;
   logic          busIo;
   logic          busAcRef;
   memPkg::devNum busDev;
   memPkg::ioAddr busIoAddr;

   // Cycle flags
   assign busRead   = busAddr[memPkg::flagRead];
   assign busWrTest = busAddr[memPkg::flagWrTest];
   assign busWrite  = busAddr[memPkg::flagWrite];
   assign busIo     = busAddr[memPkg::flagIo];
   assign busAcRef  = busAddr[memPkg::flagAcRef];

   // Device and IO register address
   assign busDev    = busAddr[memPkg::devFirst:memPkg::devLast];
   assign busIoAddr = busAddr[memPkg::ioAddrFirst:memPkg::wordLast];

   ////////////////////////////////////////
   // Cycle classification
   ////////////////////////////////////////

   logic msrSel;
   logic msrRead;
   logic memCycle;

   // Our device number and the status register address
   assign msrSel = busIo && (busDev == memDev) && (busIoAddr == msrAddr);

   // Status register read
   assign msrRead = busReq && busRead && msrSel;

   // Any memory cycle including AC references
   assign memCycle = busReq && !busIo && (busRead || busWrite || busWrTest);

   // Decoded cycle toward the status register and the SRAM
   assign req.memRead  = busReq && busRead && !busIo;
   assign req.memWrite = busReq && busWrite && !busIo && !busAcRef;
   assign req.msrWrite = busReq && busWrite && msrSel;
   assign req.addr     = busAddr[memPkg::memAddrFirst:memPkg::wordLast];
   assign req.wrData   = busDataIn;

   ////////////////////////////////////////
   // Acknowledge and read data
   ////////////////////////////////////////

   assign busAck = msrRead || memCycle;

   // SRAM data for memory, status word for the register, else zero
   always_comb
   begin
      if (memCycle)
         busDataOut = ssramRdData;
      else if (msrRead)
         busDataOut = statWord;
      else
         busDataOut = '0;
   end

endmodule

/* design/memStatusReg.sv */
// Memory status register
`timescale 1ns/1ps

module memStatusReg (
   input  logic           clkR,
   input  logic           rst,
   memReqIf.sink          req,
   output memPkg::busWord statWord
);

   ////////////////////////////////////////
   // Status bits
   ////////////////////////////////////////

   logic statPe;  // Parity error
   logic statEe;  // ECC enable
   logic statPf;  // Power failure

   // Power-up state, ECC on and power fail flagged
   always_ff @(posedge clkR or posedge rst)
   begin
      if (rst)
      begin
         statPe <= 1'b0;
         statEe <= 1'b1;
         statPf <= 1'b1;
      end
      else if (req.msrWrite)
      begin
         // PE is plain read and write
         statPe <= req.wrData[memPkg::statBitPe];
         // PF can only be cleared by software
         statPf <= statPf && req.wrData[memPkg::statBitPf];
         // Writing ED disables ECC, so EE reads inverted
         statEe <= !req.wrData[memPkg::statBitEd];
      end
   end

   ////////////////////////////////////////
   // Read word
   ////////////////////////////////////////

   // Unimplemented fields read as zero
   always_comb
   begin
      statWord                    = '0;
      statWord[memPkg::statBitPe] = statPe;
      statWord[memPkg::statBitEe] = statEe;
      statWord[memPkg::statBitPf] = statPf;
   end

endmodule

/* design/ssramCtrl.sv */
// Synchronous SRAM strobe controller
`timescale 1ns/1ps

module ssramCtrl (
   input  logic            clkR,
   input  logic            rst,
   input  memPkg::phaseVec phase,
   memReqIf.sink           req,
   output memPkg::memAddr  ssramAddr,
   output logic            ssramWeN,
   output logic            ssramOeN,
   output memPkg::busWord  ssramDataOut,
   output logic            ssramDataOe
);

   ////////////////////////////////////////
   // Strobes, one phase ahead
   ////////////////////////////////////////

   logic weNext;
   logic oeNext;
   logic dataOeNext;

   // Write strobe in phase 2, set up during phase 1
   assign weNext = !(req.memWrite && phase[1]);

   // Output enable in phase 4, set up during phase 3
   assign oeNext = !(req.memRead && phase[3]);

   // Drive write data through phases 2 to 4
   assign dataOeNext = req.memWrite && (phase[1] || phase[2] || phase[3]);

   always_ff @(posedge clkR or posedge rst)
   begin
      if (rst)
      begin
         ssramWeN    <= 1'b1;
         ssramOeN    <= 1'b1;
         ssramDataOe <= 1'b0;
      end
      else
      begin
         ssramWeN    <= weNext;
         ssramOeN    <= oeNext;
         ssramDataOe <= dataOeNext;
      end
   end

   // Address and data registered alongside the strobes
   always_ff @(posedge clkR)
   begin
      ssramAddr    <= req.addr;
      ssramDataOut <= req.wrData;
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Write and read strobes never overlap
   strobeExclusive : assert property (
      @(posedge clkR) disable iff (rst) !(!ssramWeN && !ssramOeN)
   );

   // No bus contention with the SRAM driving read data
   dataContention : assert property (
      @(posedge clkR) disable iff (rst) !(ssramDataOe && !ssramOeN)
   );

endmodule

/* design/memTop.sv */
// Memory subsystem top level
`timescale 1ns/1ps

module memTop #(
   parameter memPkg::devNum memDev  = 4'd0,
   parameter memPkg::ioAddr msrAddr = 18'o100000
) (
   input  logic            clkR,
   input  logic            rst,
   input  logic            busReq,
   input  memPkg::busWord  busAddr,
   input  memPkg::busWord  busDataIn,
   output logic            busAck,
   output memPkg::busWord  busDataOut,
   output memPkg::phaseVec clkPhase,
   output memPkg::memAddr  ssramAddr,
   output logic            ssramWeN,
   output logic            ssramOeN,
   output memPkg::busWord  ssramDataOut,
   output logic            ssramDataOe,
   input  memPkg::busWord  ssramDataIn
);

   ////////////////////////////////////////
   // Internal connections
   ////////////////////////////////////////

   // Decoded bus cycle
   memReqIf req ();

   // Status register read word
   memPkg::busWord statWord;

   ////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////

   // Phase sequencer, also seen by the bus master
   clkPhaseSeq uPhaseSeq (
      .clkR  (clkR),
      .rst   (rst),
      .phase (clkPhase)
   );

   // Bus decode, acknowledge and read mux
   memBusDecode #(
      .memDev  (memDev),
      .msrAddr (msrAddr)
   ) uBusDecode (
      .busReq      (busReq),
      .busAddr     (busAddr),
      .busDataIn   (busDataIn),
      .ssramRdData (ssramDataIn),
      .statWord    (statWord),
      .busAck      (busAck),
      .busDataOut  (busDataOut),
      .req         (req.src)
   );

   // PE, EE and PF bits
   memStatusReg uStatusReg (
      .clkR     (clkR),
      .rst      (rst),
      .req      (req.sink),
      .statWord (statWord)
   );

   // SRAM strobes and write path
   ssramCtrl uSsramCtrl (
      .clkR         (clkR),
      .rst          (rst),
      .phase        (clkPhase),
      .req          (req.sink),
      .ssramAddr    (ssramAddr),
      .ssramWeN     (ssramWeN),
      .ssramOeN     (ssramOeN),
      .ssramDataOut (ssramDataOut),
      .ssramDataOe  (ssramDataOe)
   );

endmodule

/* testbench/clkGen.sv */
// Testbench clock source
`timescale 1ns/1ps

module clkGen #(
   parameter int periodNs = 100
) (
   output logic clkR
);

   // Free-running square wave, low at time zero
   initial
   begin
      clkR = 1'b0;
   end

   always
   begin
      #(periodNs / 2) clkR = ~clkR;
   end

endmodule

/* testbench/ssramModel.sv */
// Behavioral synchronous SRAM
`timescale 1ns/1ps

module ssramModel (
   input  logic           clkR,
   input  memPkg::memAddr addr,
   input  logic           weN,
   input  logic           oeN,
   input  memPkg::busWord dataIn,
   input  logic           dataOe,
   output memPkg::busWord dataOut
);

   // 1M words of 36 bits
   memPkg::busWord mem [0:(1 << 20) - 1];

   // Fill from the full address so stale reads stand out
   initial
   begin
      for (int i = 0; i < (1 << 20); i++)
         mem[i] = {~i[15:0], i[19:0]};
   end

   // Write on the clock edge that closes the strobe
   always @(posedge clkR)
   begin
      if (!weN && dataOe)
         mem[addr] <= dataIn;
   end

   // Read data only while output enable is low
   assign dataOut = oeN ? '0 : mem[addr];

endmodule

/* testbench/memTb.sv */
// Memory subsystem testbench
`timescale 1ns/1ps

module memTb;

   ////////////////////////////////////////
   // Run setup
   ////////////////////////////////////////

   localparam int clkPeriodNs  = 100;
   localparam int resetCycles  = 16;
   localparam int marginCycles = 24;

   // Device number and status register address under test
   localparam memPkg::devNum tbDev     = 4'd5;
   localparam memPkg::ioAddr tbMsrAddr = 18'o100002;

   ////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      opMemWrite,
      opMemRead,
      opWrTest,
      opAcRefWrite,
      opMsrWrite,
      opIoRead
   } opKind;

   typedef struct packed {
      opKind          op;
      logic           req;
      memPkg::busWord flags;
      memPkg::busWord addr;
      memPkg::busWord data;
      logic           expAck;
      memPkg::busWord expData;
   } stimEntry;

   stimEntry stimTable [$];
   int       tableLen;

   // Expected memory and status bits
   memPkg::busWord refMem [memPkg::memAddr];
   logic           refPe;
   logic           refEe;
   logic           refPf;

   logic [15:0] lfsrState;
   int          checkCount;
   int          ackErrors;
   int          wordErrors;

   ////////////////////////////////////////
   // DUT and SRAM
   ////////////////////////////////////////

   logic            clkR;
   logic            rst;
   logic            busReq;
   memPkg::busWord  busAddr;
   memPkg::busWord  busDataIn;
   logic            busAck;
   memPkg::busWord  busDataOut;
   memPkg::phaseVec clkPhase;
   memPkg::memAddr  ssramAddr;
   logic            ssramWeN;
   logic            ssramOeN;
   memPkg::busWord  ssramDataOut;
   logic            ssramDataOe;
   memPkg::busWord  ssramDataIn;

   clkGen #(.periodNs (clkPeriodNs)) uClkGen (.clkR (clkR));

   memTop #(
      .memDev  (tbDev),
      .msrAddr (tbMsrAddr)
   ) u_dut (
      .clkR         (clkR),
      .rst          (rst),
      .busReq       (busReq),
      .busAddr      (busAddr),
      .busDataIn    (busDataIn),
      .busAck       (busAck),
      .busDataOut   (busDataOut),
      .clkPhase     (clkPhase),
      .ssramAddr    (ssramAddr),
      .ssramWeN     (ssramWeN),
      .ssramOeN     (ssramOeN),
      .ssramDataOut (ssramDataOut),
      .ssramDataOe  (ssramDataOe),
      .ssramDataIn  (ssramDataIn)
   );

   ssramModel uSram (
      .clkR    (clkR),
      .addr    (ssramAddr),
      .weN     (ssramWeN),
      .oeN     (ssramOeN),
      .dataIn  (ssramDataOut),
      .dataOe  (ssramDataOe),
      .dataOut (ssramDataIn)
   );

   ////////////////////////////////////////
   // Random source
   ////////////////////////////////////////

   // 16-bit Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsrNext(input logic [15:0] state);
      logic feedback;
      feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
      return {state[14:0], feedback};
   endfunction

   // One step per bit
   function logic takeBit();
      lfsrState = lfsrNext(lfsrState);
      return lfsrState[0];
   endfunction

   function memPkg::busWord randomWord();
      memPkg::busWord w;
      for (int i = 0; i <= 35; i++)
         w[i] = takeBit();
      return w;
   endfunction

   function memPkg::memAddr randomAddr();
      memPkg::memAddr a;
      for (int i = 16; i <= 35; i++)
         a[i] = takeBit();
      return a;
   endfunction

   ////////////////////////////////////////
   // Address word and expected values
   ////////////////////////////////////////

   function automatic memPkg::busWord flagWord(input int pos);
      memPkg::busWord w;
      w      = '0;
      w[pos] = 1'b1;
      return w;
   endfunction

   // Memory address in bits 16 to 35
   function automatic memPkg::busWord memField(input memPkg::memAddr a);
      memPkg::busWord w;
      w        = '0;
      w[16:35] = a;
      return w;
   endfunction

   // Device in bits 14 to 17 and register in 18 to 35
   function automatic memPkg::busWord ioField(input memPkg::devNum d, input memPkg::ioAddr a);
      memPkg::busWord w;
      w        = '0;
      w[14:17] = d;
      w[18:35] = a;
      return w;
   endfunction

   // PE at 3, EE at 4 and PF at 12
   function memPkg::busWord statusWord();
      memPkg::busWord w;
      w     = '0;
      w[3]  = refPe;
      w[4]  = refEe;
      w[12] = refPf;
      return w;
   endfunction

   function automatic string opLabel(input opKind op);
      return op.name();
   endfunction

   ////////////////////////////////////////
   // Table building
   ////////////////////////////////////////

   task automatic addEntry(input opKind op, input logic req, input memPkg::busWord flags,
                           input memPkg::busWord addr, input memPkg::busWord data,
                           input logic expAck, input memPkg::busWord expData);
      stimEntry e;
      e.op      = op;
      e.req     = req;
      e.flags   = flags;
      e.addr    = addr;
      e.data    = data;
      e.expAck  = expAck;
      e.expData = expData;
      stimTable.push_back(e);
   endtask

   task automatic addMemWrite(input memPkg::memAddr a, input memPkg::busWord d);
      addEntry(opMemWrite, 1'b1, flagWord(memPkg::flagWrite), memField(a), d, 1'b1, '0);
      refMem[a] = d;
   endtask

   // Acknowledged only with busReq high
   task automatic addMemRead(input logic req, input memPkg::memAddr a);
      addEntry(opMemRead, req, flagWord(memPkg::flagRead), memField(a), '0, req,
               req ? refMem[a] : '0);
   endtask

   task automatic addWrTest(input memPkg::memAddr a, input memPkg::busWord d);
      addEntry(opWrTest, 1'b1, flagWord(memPkg::flagWrTest), memField(a), d, 1'b1, '0);
   endtask

   // Acknowledged but memory keeps its old word
   task automatic addAcRefWrite(input memPkg::memAddr a, input memPkg::busWord d);
      addEntry(opAcRefWrite, 1'b1, flagWord(memPkg::flagWrite) | flagWord(memPkg::flagAcRef),
               memField(a), d, 1'b1, '0);
   endtask

   // No acknowledge for register writes
   task automatic addMsrWrite(input memPkg::busWord d);
      addEntry(opMsrWrite, 1'b1, flagWord(memPkg::flagIo) | flagWord(memPkg::flagWrite),
               ioField(tbDev, tbMsrAddr), d, 1'b0, '0);
      refPe = d[3];
      refPf = refPf & d[12];
      refEe = ~d[35];
   endtask

   // Only our device at the status address answers
   task automatic addIoRead(input logic req, input memPkg::devNum d, input memPkg::ioAddr a);
      logic hit;
      hit = req && (d == tbDev) && (a == tbMsrAddr);
      addEntry(opIoRead, req, flagWord(memPkg::flagIo) | flagWord(memPkg::flagRead),
               ioField(d, a), '0, hit, hit ? statusWord() : '0);
   endtask

   task automatic buildTable();
      memPkg::memAddr wrAddr [4];
      memPkg::busWord wrData [4];
      memPkg::busWord d;
      // Power-up status
      refPe = 1'b0;
      refEe = 1'b1;
      refPf = 1'b1;
      addIoRead(1'b1, tbDev, tbMsrAddr);
      // Writes then readback
      for (int i = 0; i < 4; i++)
      begin
         wrAddr[i] = randomAddr();
         wrData[i] = randomWord();
         addMemWrite(wrAddr[i], wrData[i]);
      end
      for (int i = 0; i < 4; i++)
         addMemRead(1'b1, wrAddr[i]);
      addWrTest(randomAddr(), randomWord());
      // Set PE, keep PF, ED clear
      d     = randomWord();
      d[3]  = 1'b1;
      d[12] = 1'b1;
      d[35] = 1'b0;
      addMsrWrite(d);
      addIoRead(1'b1, tbDev, tbMsrAddr);
      // Clear PE and PF, set ED
      d     = randomWord();
      d[3]  = 1'b0;
      d[12] = 1'b0;
      d[35] = 1'b1;
      addMsrWrite(d);
      addIoRead(1'b1, tbDev, tbMsrAddr);
      // PF stays cleared
      d     = randomWord();
      d[3]  = 1'b1;
      d[12] = 1'b1;
      d[35] = 1'b0;
      addMsrWrite(d);
      addIoRead(1'b1, tbDev, tbMsrAddr);
      // AC reference write then check old data
      addAcRefWrite(wrAddr[0], ~wrData[0]);
      addMemRead(1'b1, wrAddr[0]);
      // Misses and idle bus
      addIoRead(1'b1, tbDev + 4'd1, tbMsrAddr);
      addIoRead(1'b1, tbDev, tbMsrAddr + 18'd1);
      addIoRead(1'b0, tbDev, tbMsrAddr);
      addMemRead(1'b0, wrAddr[1]);
   endtask

   ////////////////////////////////////////
   // Drive and compare
   ////////////////////////////////////////

   // Next falling edge inside the given phase
   task automatic waitPhase(input int n);
      do
         @(negedge clkR);
      while (clkPhase[n] !== 1'b1);
   endtask

   task automatic driveEntry(input stimEntry e);
      busReq    = e.req;
      busAddr   = e.flags | e.addr;
      busDataIn = e.data;
   endtask

   task automatic checkAck(input int entry, input string op, input logic expected,
                           input logic actual);
      checkCount++;
      if (actual !== expected)
      begin
         ackErrors++;
         $display("FAIL entry %0d %s busAck expected %h got %h", entry, op, expected, actual);
      end
   endtask

   task automatic checkWord(input int entry, input string op, input string sigName,
                            input memPkg::busWord expected, input memPkg::busWord actual);
      checkCount++;
      if (actual !== expected)
      begin
         wordErrors++;
         $display("FAIL entry %0d %s %s expected %h got %h",
                  entry, op, sigName, expected, actual);
      end
   endtask

   task automatic printSummary();
      $display("Checks %0d, busAck errors %0d, busDataOut errors %0d",
               checkCount, ackErrors, wordErrors);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      rst        = 1'b1;
      busReq     = 1'b0;
      busAddr    = '0;
      busDataIn  = '0;
      lfsrState  = 16'd64601;
      checkCount = 0;
      ackErrors  = 0;
      wordErrors = 0;
      buildTable();
      tableLen = stimTable.size();
      repeat (resetCycles) @(negedge clkR);
      rst = 1'b0;
      // One entry per phase rotation and sampled in phase 4
      for (int i = 0; i < tableLen; i++)
      begin
         waitPhase(1);
         driveEntry(stimTable[i]);
         waitPhase(4);
         checkAck(i, opLabel(stimTable[i].op), stimTable[i].expAck, busAck);
         checkWord(i, opLabel(stimTable[i].op), "busDataOut", stimTable[i].expData, busDataOut);
      end
      waitPhase(1);
      busReq    = 1'b0;
      busAddr   = '0;
      busDataIn = '0;
      printSummary();
      if (ackErrors + wordErrors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // Watchdog allows four clocks per entry plus reset and slack
   initial
   begin
      wait (tableLen > 0);
      #((tableLen * 4 + resetCycles + marginCycles) * clkPeriodNs);
      $display("Timeout: the table of %0d entries did not finish in time", tableLen);
      printSummary();
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* compile.f */
design/memPkg.sv
design/memReqIf.sv
design/clkPhaseSeq.sv
design/memBusDecode.sv
design/memStatusReg.sv
design/ssramCtrl.sv
design/memTop.sv
testbench/clkGen.sv
testbench/ssramModel.sv
testbench/memTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --timing --assert
TOP       = memTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log
FAILMSG   = ERRORS FOUND

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
